//--- rtl/chan_pkg.sv
// chan_pkg: sizes, sample and tap types, and FSM states for the four-channel PFB channelizer
`default_nettype none

package chan_pkg;

  // channel count equals the number of polyphase branches
  localparam int NUM_CHAN       = 4;
  localparam int TAPS_PER_PHASE = 4;
  // one coefficient memory holds every branch
  localparam int NUM_TAPS       = NUM_CHAN * TAPS_PER_PHASE;

  // real or imaginary part of a sample
  typedef logic signed [15:0] sample_t;
  // coefficient, Q1.15
  typedef logic signed [15:0] tap_t;
  // address = phase + 4 * tap
  typedef logic [3:0] tap_addr_t;
  typedef logic [1:0] chan_idx_t;
  // bit k enables channel k
  typedef logic [NUM_CHAN-1:0] mask_t;

  // complex sample on every data path
  typedef struct packed {
    sample_t re;
    sample_t im;
  } iq_t;

  // one entry per branch or per channel
  typedef iq_t [NUM_CHAN-1:0] block_t;

  // filter sequencer
  typedef enum logic [1:0] {
    FILT_COLLECT,
    FILT_REQUEST,
    FILT_ACCUM,
    FILT_EMIT
  } filt_state_t;

  // output sequencer
  typedef enum logic {
    SEL_IDLE,
    SEL_SCAN
  } sel_state_t;

endpackage

`default_nettype wire

//--- rtl/tap_ram_arbiter.sv
// tap_ram_arbiter: coefficient memory shared by reload writer and filter reader, reads win
`timescale 1ns/1ps
`default_nettype none

module tap_ram_arbiter
  import chan_pkg::*;
(
  input  logic      clk,
  input  logic      arst_n_i,
  // reload stream, sequential addresses
  input  logic      wr_valid_i,
  input  tap_t      wr_data_i,
  input  logic      wr_last_i,
  output logic      wr_ready_o,
  // filter read port, data one cycle after request
  input  logic      rd_req_i,
  input  tap_addr_t rd_addr_i,
  output tap_t      rd_data_o
);

  tap_t      mem_q [NUM_TAPS];
  tap_addr_t wr_addr_q;
  tap_t      rd_data_q;
  logic      wr_fire;

  // fixed priority: a filter request always gets the memory
  assign wr_ready_o = !rd_req_i;
  assign wr_fire    = wr_valid_i && wr_ready_o;

  // taps come up as zero, testbench loads them before data
  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_addr_q <= '0;
      for (int i = 0; i < NUM_TAPS; i++) begin
        mem_q[i] <= '0;
      end
    end else if (wr_fire) begin
      mem_q[wr_addr_q] <= wr_data_i;
      // last closes a reload, so the next one starts at address 0
      if (wr_last_i) begin
        wr_addr_q <= '0;
      end else begin
        wr_addr_q <= wr_addr_q + 1'b1;
      end
    end
  end

  // granted read, registered output
  always_ff @(posedge clk) begin
    if (rd_req_i) begin
      rd_data_q <= mem_q[rd_addr_i];
    end
  end

  assign rd_data_o = rd_data_q;

endmodule

`default_nettype wire

//--- rtl/pfb_filter.sv
// pfb_filter: commutator, four branch delay lines and the MAC sequencer for one block
`timescale 1ns/1ps
`default_nettype none

module pfb_filter
  import chan_pkg::*;
(
  input  logic      clk,
  input  logic      arst_n_i,
  input  logic      in_valid_i,
  input  iq_t       in_data_i,
  output logic      in_ready_o,
  output logic      rd_req_o,
  output tap_addr_t rd_addr_o,
  input  tap_t      rd_data_i,
  output logic      blk_valid_o,
  output block_t    blk_data_o,
  input  logic      blk_ready_i
);

  filt_state_t        state_q;
  chan_idx_t          phase_q;
  tap_addr_t          cnt_q;
  logic               mac_en_q;
  tap_addr_t          mac_addr_q;
  iq_t                line_q [NUM_CHAN][TAPS_PER_PHASE];
  logic signed [33:0] acc_re_q [NUM_CHAN];
  logic signed [33:0] acc_im_q [NUM_CHAN];
  iq_t                mac_smp;
  logic signed [31:0] prod_re;
  logic signed [31:0] prod_im;
  logic               in_fire;
  logic               blk_start;

  // drop 15 fraction bits, clip to the sample range
  function automatic sample_t sat15(input logic signed [33:0] a);
    logic signed [18:0] s;
    s = 19'(a >>> 15);
    if (s > 19'sd32767) begin
      return 16'sh7fff;
    end else if (s < -19'sd32768) begin
      return 16'sh8000;
    end
    return s[15:0];
  endfunction

  // samples only taken while collecting
  assign in_ready_o = (state_q == FILT_COLLECT);
  assign in_fire    = in_valid_i && in_ready_o;
  // fourth sample of a block
  assign blk_start  = in_fire && (phase_q == chan_idx_t'(NUM_CHAN - 1));

  // one tap read per cycle, address walks 0..15
  assign rd_req_o  = (state_q == FILT_REQUEST);
  assign rd_addr_o = cnt_q;

  // sequencer: 16 reads, one drain cycle, then hold the block
  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q    <= FILT_COLLECT;
      phase_q    <= '0;
      cnt_q      <= '0;
      mac_en_q   <= 1'b0;
      mac_addr_q <= '0;
    end else begin
      // read data lands one cycle after the request
      mac_en_q   <= rd_req_o;
      mac_addr_q <= cnt_q;
      case (state_q)
        FILT_COLLECT: begin
          if (in_fire) begin
            phase_q <= phase_q + 1'b1;
          end
          if (blk_start) begin
            cnt_q   <= '0;
            state_q <= FILT_REQUEST;
          end
        end
        FILT_REQUEST: begin
          cnt_q <= cnt_q + 1'b1;
          if (cnt_q == tap_addr_t'(NUM_TAPS - 1)) begin
            state_q <= FILT_ACCUM;
          end
        end
        // last tap accumulates here
        FILT_ACCUM: state_q <= FILT_EMIT;
        FILT_EMIT: begin
          if (blk_ready_i) begin
            state_q <= FILT_COLLECT;
          end
        end
        default: state_q <= FILT_COLLECT;
      endcase
    end
  end

  // commutator: sample n into branch n mod 4, newest at index 0
  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      for (int p = 0; p < NUM_CHAN; p++) begin
        for (int k = 0; k < TAPS_PER_PHASE; k++) begin
          line_q[p][k] <= '0;
        end
      end
    end else if (in_fire) begin
      for (int k = TAPS_PER_PHASE - 1; k > 0; k--) begin
        line_q[phase_q][k] <= line_q[phase_q][k-1];
      end
      line_q[phase_q][0] <= in_data_i;
    end
  end

  // address bits pick branch (low) and age (high)
  assign mac_smp = line_q[mac_addr_q[1:0]][mac_addr_q[3:2]];
  // real tap times complex sample
  assign prod_re = mac_smp.re * rd_data_i;
  assign prod_im = mac_smp.im * rd_data_i;

  always_ff @(posedge clk) begin
    if (blk_start) begin
      for (int p = 0; p < NUM_CHAN; p++) begin
        acc_re_q[p] <= '0;
        acc_im_q[p] <= '0;
      end
    end else if (mac_en_q) begin
      acc_re_q[mac_addr_q[1:0]] <= acc_re_q[mac_addr_q[1:0]] + prod_re;
      acc_im_q[mac_addr_q[1:0]] <= acc_im_q[mac_addr_q[1:0]] + prod_im;
    end
  end

  assign blk_valid_o = (state_q == FILT_EMIT);

  always_comb begin
    for (int p = 0; p < NUM_CHAN; p++) begin
      blk_data_o[p].re = sat15(acc_re_q[p]);
      blk_data_o[p].im = sat15(acc_im_q[p]);
    end
  end

endmodule

`default_nettype wire

//--- rtl/dft4.sv
// dft4: multiplier-free 4-point DFT over branch outputs, one registered block
`timescale 1ns/1ps
`default_nettype none

module dft4
  import chan_pkg::*;
(
  input  logic   clk,
  input  logic   arst_n_i,
  input  logic   blk_valid_i,
  input  block_t blk_data_i,
  output logic   blk_ready_o,
  output logic   chan_valid_o,
  output block_t chan_data_o,
  input  logic   chan_ready_i
);

  logic signed [17:0] a_re, a_im, b_re, b_im;
  logic signed [17:0] c_re, c_im, d_re, d_im;
  block_t             x;
  logic               chan_valid_q;
  block_t             chan_data_q;

  // divide by 4, always fits 16 bits after the shift
  function automatic sample_t quarter(input logic signed [17:0] v);
    logic signed [17:0] s;
    s = v >>> 2;
    return s[15:0];
  endfunction

  // first stage: even and odd pairs
  assign a_re = blk_data_i[0].re + blk_data_i[2].re;
  assign a_im = blk_data_i[0].im + blk_data_i[2].im;
  assign b_re = blk_data_i[0].re - blk_data_i[2].re;
  assign b_im = blk_data_i[0].im - blk_data_i[2].im;
  assign c_re = blk_data_i[1].re + blk_data_i[3].re;
  assign c_im = blk_data_i[1].im + blk_data_i[3].im;
  assign d_re = blk_data_i[1].re - blk_data_i[3].re;
  assign d_im = blk_data_i[1].im - blk_data_i[3].im;

  // second stage, -j*d is (d.im, -d.re)
  always_comb begin
    x[0].re = quarter(a_re + c_re);
    x[0].im = quarter(a_im + c_im);
    x[1].re = quarter(b_re + d_im);
    x[1].im = quarter(b_im - d_re);
    x[2].re = quarter(a_re - c_re);
    x[2].im = quarter(a_im - c_im);
    x[3].re = quarter(b_re - d_im);
    x[3].im = quarter(b_im + d_re);
  end

  // room when empty or draining this cycle
  assign blk_ready_o = !chan_valid_q || chan_ready_i;

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      chan_valid_q <= 1'b0;
    end else if (blk_ready_o) begin
      chan_valid_q <= blk_valid_i;
    end
  end

  always_ff @(posedge clk) begin
    if (blk_valid_i && blk_ready_o) begin
      chan_data_q <= x;
    end
  end

  assign chan_valid_o = chan_valid_q;
  assign chan_data_o  = chan_data_q;

endmodule

`default_nettype wire

//--- rtl/chan_select.sv
// chan_select: channel mask and output sequencer, emits selected channels with user and last
`timescale 1ns/1ps
`default_nettype none

module chan_select
  import chan_pkg::*;
(
  input  logic        clk,
  input  logic        arst_n_i,
  input  logic        sel_valid_i,
  input  logic [31:0] sel_data_i,
  input  logic        chan_valid_i,
  input  block_t      chan_data_i,
  output logic        chan_ready_o,
  output logic        out_valid_o,
  output iq_t         out_data_o,
  output chan_idx_t   out_user_o,
  output logic        out_last_o,
  input  logic        out_ready_i
);

  sel_state_t state_q;
  mask_t      mask_q;
  mask_t      cur_mask_q;
  chan_idx_t  idx_q;
  chan_idx_t  last_idx;
  block_t     buf_q;
  logic       blk_fire;

  // lowest set bit at or above start
  function automatic chan_idx_t first_from(input mask_t m, input int start);
    chan_idx_t r;
    r = '0;
    for (int i = NUM_CHAN - 1; i >= 0; i--) begin
      if (m[i] && (i >= start)) begin
        r = chan_idx_t'(i);
      end
    end
    return r;
  endfunction

  // highest selected channel carries last
  always_comb begin
    last_idx = '0;
    for (int i = 0; i < NUM_CHAN; i++) begin
      if (cur_mask_q[i]) begin
        last_idx = chan_idx_t'(i);
      end
    end
  end

  assign chan_ready_o = (state_q == SEL_IDLE);
  assign blk_fire     = chan_valid_i && chan_ready_o;

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q    <= SEL_IDLE;
      mask_q     <= '1;
      cur_mask_q <= '1;
      idx_q      <= '0;
    end else begin
      // select port is always ready
      if (sel_valid_i) begin
        mask_q <= sel_data_i[NUM_CHAN-1:0];
      end
      case (state_q)
        SEL_IDLE: begin
          // mask sampled at the block boundary, zero mask swallows the block
          if (blk_fire) begin
            cur_mask_q <= mask_q;
            idx_q      <= first_from(mask_q, 0);
            if (mask_q != '0) begin
              state_q <= SEL_SCAN;
            end
          end
        end
        SEL_SCAN: begin
          if (out_ready_i) begin
            if (idx_q == last_idx) begin
              state_q <= SEL_IDLE;
            end else begin
              idx_q <= first_from(cur_mask_q, int'(idx_q) + 1);
            end
          end
        end
        default: state_q <= SEL_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (blk_fire) begin
      buf_q <= chan_data_i;
    end
  end

  assign out_valid_o = (state_q == SEL_SCAN);
  assign out_data_o  = buf_q[idx_q];
  assign out_user_o  = idx_q;
  assign out_last_o  = (idx_q == last_idx);

endmodule

`default_nettype wire

//--- rtl/chan_top.sv
// chan_top: four-channel polyphase channelizer, sample/reload/select streams in, channels out
`timescale 1ns/1ps
`default_nettype none

module chan_top
  import chan_pkg::*;
(
  input  logic        clk,
  input  logic        arst_n_i,
  // sample stream
  input  logic        s_sample_valid_i,
  input  iq_t         s_sample_data_i,
  output logic        s_sample_ready_o,
  // coefficient reload stream
  input  logic        s_reload_valid_i,
  input  tap_t        s_reload_data_i,
  input  logic        s_reload_last_i,
  output logic        s_reload_ready_o,
  // channel select, always ready
  input  logic        s_select_valid_i,
  input  logic [31:0] s_select_data_i,
  // channel output stream
  output logic        m_out_valid_o,
  output iq_t         m_out_data_o,
  output chan_idx_t   m_out_user_o,
  output logic        m_out_last_o,
  input  logic        m_out_ready_i
);

  logic      rd_req;
  tap_addr_t rd_addr;
  tap_t      rd_data;
  logic      blk_valid;
  block_t    blk_data;
  logic      blk_ready;
  logic      chan_valid;
  block_t    chan_data;
  logic      chan_ready;

  // tap memory, filter reads before reload writes
  tap_ram_arbiter i_tap_ram (
    .clk        (clk),
    .arst_n_i   (arst_n_i),
    .wr_valid_i (s_reload_valid_i),
    .wr_data_i  (s_reload_data_i),
    .wr_last_i  (s_reload_last_i),
    .wr_ready_o (s_reload_ready_o),
    .rd_req_i   (rd_req),
    .rd_addr_i  (rd_addr),
    .rd_data_o  (rd_data)
  );

  pfb_filter i_filter (
    .clk         (clk),
    .arst_n_i    (arst_n_i),
    .in_valid_i  (s_sample_valid_i),
    .in_data_i   (s_sample_data_i),
    .in_ready_o  (s_sample_ready_o),
    .rd_req_o    (rd_req),
    .rd_addr_o   (rd_addr),
    .rd_data_i   (rd_data),
    .blk_valid_o (blk_valid),
    .blk_data_o  (blk_data),
    .blk_ready_i (blk_ready)
  );

  dft4 i_dft (
    .clk          (clk),
    .arst_n_i     (arst_n_i),
    .blk_valid_i  (blk_valid),
    .blk_data_i   (blk_data),
    .blk_ready_o  (blk_ready),
    .chan_valid_o (chan_valid),
    .chan_data_o  (chan_data),
    .chan_ready_i (chan_ready)
  );

  chan_select i_select (
    .clk          (clk),
    .arst_n_i     (arst_n_i),
    .sel_valid_i  (s_select_valid_i),
    .sel_data_i   (s_select_data_i),
    .chan_valid_i (chan_valid),
    .chan_data_i  (chan_data),
    .chan_ready_o (chan_ready),
    .out_valid_o  (m_out_valid_o),
    .out_data_o   (m_out_data_o),
    .out_user_o   (m_out_user_o),
    .out_last_o   (m_out_last_o),
    .out_ready_i  (m_out_ready_i)
  );

endmodule

`default_nettype wire

//--- sim/chan_checker.sv
// chan_checker: reference model of filter, DFT and channel mask, compares DUT output beats
`timescale 1ns/1ps
`default_nettype none

module chan_checker
  import chan_pkg::*;
(
  input logic        clk,
  input logic        arst_n_i,
  input logic        s_sample_valid_i,
  input iq_t         s_sample_data_i,
  input logic        s_sample_ready_i,
  input logic        s_reload_valid_i,
  input tap_t        s_reload_data_i,
  input logic        s_reload_last_i,
  input logic        s_reload_ready_i,
  input logic        s_select_valid_i,
  input logic [31:0] s_select_data_i,
  input logic        m_out_valid_i,
  input iq_t         m_out_data_i,
  input chan_idx_t   m_out_user_i,
  input logic        m_out_last_i,
  input logic        m_out_ready_i
);

  // fourth sample to block valid, sample ready held low throughout
  localparam int COMPUTE_CYCLES = 17;

  // one output beat as seen on m_out
  typedef struct packed {
    iq_t       data;
    chan_idx_t user;
    logic      last;
  } beat_t;

  // model state, mirrors what the stream rules imply
  tap_t  taps_m [NUM_TAPS];
  iq_t   line_m [NUM_CHAN][TAPS_PER_PHASE];
  int    phase_m;
  int    wr_addr_m;
  int    busy_m;
  mask_t mask_m;
  beat_t exp_q [$];

  string cur_name;
  int    test_cnt;
  int    fail_cnt;
  int    test_errs;
  int    test_beats;
  int    beat_cnt;
  int    error_cnt;

  initial begin
    cur_name   = "none";
    test_cnt   = 0;
    fail_cnt   = 0;
    test_errs  = 0;
    test_beats = 0;
    beat_cnt   = 0;
    error_cnt  = 0;
  end

  // >>> 15 then clip to 16 bits
  function automatic sample_t scale_sat(input longint acc);
    longint s;
    s = acc >>> 15;
    if (s > 32767) begin
      return 16'sh7fff;
    end
    if (s < -32768) begin
      return 16'sh8000;
    end
    return sample_t'(s);
  endfunction

  // counted against the running test and the whole run
  task automatic count_error();
    test_errs++;
    error_cnt++;
  endtask

  // branch outputs, then channel c = sum y(p) * (-j)^(p*c), >>> 2
  task automatic push_block();
    longint acc_re;
    longint acc_im;
    longint sum_re;
    longint sum_im;
    iq_t    y [NUM_CHAN];
    int     last_c;
    beat_t  b;
    for (int p = 0; p < NUM_CHAN; p++) begin
      acc_re = 0;
      acc_im = 0;
      for (int k = 0; k < TAPS_PER_PHASE; k++) begin
        acc_re += longint'(taps_m[p + 4 * k]) * longint'(line_m[p][k].re);
        acc_im += longint'(taps_m[p + 4 * k]) * longint'(line_m[p][k].im);
      end
      y[p].re = scale_sat(acc_re);
      y[p].im = scale_sat(acc_im);
    end
    // highest selected channel closes the block
    last_c = -1;
    for (int c = 0; c < NUM_CHAN; c++) begin
      if (mask_m[c]) begin
        last_c = c;
      end
    end
    for (int c = 0; c < NUM_CHAN; c++) begin
      if (mask_m[c]) begin
        sum_re = 0;
        sum_im = 0;
        for (int p = 0; p < NUM_CHAN; p++) begin
          // powers of -j: 1, -j, -1, +j
          case ((p * c) % 4)
            0: begin
              sum_re += longint'(y[p].re);
              sum_im += longint'(y[p].im);
            end
            1: begin
              sum_re += longint'(y[p].im);
              sum_im -= longint'(y[p].re);
            end
            2: begin
              sum_re -= longint'(y[p].re);
              sum_im -= longint'(y[p].im);
            end
            default: begin
              sum_re -= longint'(y[p].im);
              sum_im += longint'(y[p].re);
            end
          endcase
        end
        b.data.re = sample_t'(sum_re >>> 2);
        b.data.im = sample_t'(sum_im >>> 2);
        b.user    = chan_idx_t'(c);
        b.last    = (c == last_c);
        exp_q.push_back(b);
      end
    end
  endtask

  // commutator: sample n to branch n mod 4, newest at age 0
  task automatic take_sample();
    for (int k = TAPS_PER_PHASE - 1; k > 0; k--) begin
      line_m[phase_m][k] = line_m[phase_m][k-1];
    end
    line_m[phase_m][0] = s_sample_data_i;
    if (phase_m == NUM_CHAN - 1) begin
      push_block();
      busy_m = COMPUTE_CYCLES;
    end
    phase_m = (phase_m + 1) % NUM_CHAN;
  endtask

  task automatic compare_beat();
    beat_t exp_b;
    beat_t act_b;
    act_b = {m_out_data_i, m_out_user_i, m_out_last_i};
    test_beats++;
    beat_cnt++;
    if (exp_q.size() == 0) begin
      $display("unexpected output beat in test %s: channel %0d arrived with none due",
               cur_name, m_out_user_i);
      count_error();
    end else begin
      exp_b = exp_q.pop_front();
      if (act_b !== exp_b) begin
        $display("FAILED %s beat %0d expected %h actual %h",
                 cur_name, test_beats, exp_b, act_b);
        count_error();
      end
    end
  endtask

  task automatic start_test(input string name);
    cur_name   = name;
    test_cnt++;
    test_errs  = 0;
    test_beats = 0;
  endtask

  // state straight out of reset, before any stimulus
  task automatic check_idle();
    if (m_out_valid_i !== 1'b0) begin
      $display("output valid is not low after reset in test %s", cur_name);
      count_error();
    end
    if (s_reload_ready_i !== 1'b1) begin
      $display("reload ready is not high after reset in test %s", cur_name);
      count_error();
    end
  endtask

  task automatic end_test();
    if (test_errs == 0) begin
      $display("test %s passed, %0d beats", cur_name, test_beats);
    end else begin
      fail_cnt++;
      $display("test %s failed, %0d problems in %0d beats", cur_name, test_errs, test_beats);
    end
  endtask

  task automatic report();
    $display("%0d tests run, %0d failed, %0d beats checked, %0d problems",
             test_cnt, fail_cnt, beat_cnt, error_cnt);
  endtask

  // expected beats not yet seen on m_out
  function automatic int outstanding();
    return exp_q.size();
  endfunction

  // transfers sampled at the rising edge, reload before sample
  always @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      for (int i = 0; i < NUM_TAPS; i++) begin
        taps_m[i] = '0;
      end
      for (int p = 0; p < NUM_CHAN; p++) begin
        for (int k = 0; k < TAPS_PER_PHASE; k++) begin
          line_m[p][k] = '0;
        end
      end
      phase_m   = 0;
      wr_addr_m = 0;
      busy_m    = 0;
      mask_m    = '1;
      exp_q.delete();
    end else begin
      // filter still computing the last block
      if (busy_m > 0) begin
        if (s_sample_ready_i) begin
          $display("sample ready went high during the filter compute phase in test %s",
                   cur_name);
          count_error();
        end
        busy_m--;
      end
      if (s_reload_valid_i && s_reload_ready_i) begin
        taps_m[wr_addr_m] = s_reload_data_i;
        wr_addr_m = s_reload_last_i ? 0 : (wr_addr_m + 1) % NUM_TAPS;
      end
      if (s_select_valid_i) begin
        mask_m = s_select_data_i[NUM_CHAN-1:0];
      end
      if (s_sample_valid_i && s_sample_ready_i) begin
        take_sample();
      end
      if (m_out_valid_i && m_out_ready_i) begin
        compare_beat();
      end
    end
  end

endmodule

`default_nettype wire

//--- sim/chan_top_tb.sv
// chan_top_tb: table-driven testbench for the four-channel PFB channelizer
`timescale 1ns/1ps
`default_nettype none

module chan_top_tb
  import chan_pkg::*;
();

  localparam int         NUM_TESTS       = 7;
  localparam int         SMP_PER_TEST    = 16;
  localparam logic [2:0] NO_RELOAD       = 3'd7;
  localparam int         WATCHDOG_CYCLES = NUM_TESTS * SMP_PER_TEST * 40 + 1000;
  localparam int         TONE_AMP        = 8000;
  localparam int         SEED            = 32'h3f73;

  typedef tap_t [NUM_TAPS-1:0]   taps_t;
  typedef iq_t [SMP_PER_TEST-1:0] samples_t;
  typedef enum {KIND_RAMP, KIND_CONST, KIND_TONE, KIND_RAND} smp_kind_t;

  // one table row, reload_blk is the block whose samples start the mid-stream reload
  typedef struct packed {
    taps_t      taps;
    taps_t      new_taps;
    samples_t   smp;
    mask_t      mask;
    logic       set_mask;
    logic       bp;
    logic [2:0] reload_blk;
  } row_t;

  logic        clk;
  logic        arst_n_i;
  logic        s_sample_valid_i;
  iq_t         s_sample_data_i;
  logic        s_sample_ready_o;
  logic        s_reload_valid_i;
  tap_t        s_reload_data_i;
  logic        s_reload_last_i;
  logic        s_reload_ready_o;
  logic        s_select_valid_i;
  logic [31:0] s_select_data_i;
  logic        m_out_valid_o;
  iq_t         m_out_data_o;
  chan_idx_t   m_out_user_o;
  logic        m_out_last_o;
  logic        m_out_ready_i;

  row_t  rows [NUM_TESTS];
  string names [NUM_TESTS];
  logic  bp_on;
  int    smp_sent;

  chan_top i_dut (.*);

  chan_checker i_chk (
    .clk              (clk),
    .arst_n_i         (arst_n_i),
    .s_sample_valid_i (s_sample_valid_i),
    .s_sample_data_i  (s_sample_data_i),
    .s_sample_ready_i (s_sample_ready_o),
    .s_reload_valid_i (s_reload_valid_i),
    .s_reload_data_i  (s_reload_data_i),
    .s_reload_last_i  (s_reload_last_i),
    .s_reload_ready_i (s_reload_ready_o),
    .s_select_valid_i (s_select_valid_i),
    .s_select_data_i  (s_select_data_i),
    .m_out_valid_i    (m_out_valid_o),
    .m_out_data_i     (m_out_data_o),
    .m_out_user_i     (m_out_user_o),
    .m_out_last_i     (m_out_last_o),
    .m_out_ready_i    (m_out_ready_i)
  );

  // 100 ns period
  always #50 clk = ~clk;

  // random back-pressure only on rows that ask for it
  always @(negedge clk) begin
    if (bp_on) begin
      m_out_ready_i = 1'($urandom);
    end else begin
      m_out_ready_i = 1'b1;
    end
  end

  // k = 0 tap of every branch at full scale
  function automatic taps_t impulse_taps();
    taps_t t;
    t = '0;
    for (int p = 0; p < NUM_CHAN; p++) begin
      t[p] = 16'sh7fff;
    end
    return t;
  endfunction

  // symmetric lowpass, branch gains stay below 1.0
  function automatic taps_t lowpass_taps();
    taps_t t;
    tap_t  half [8] = '{16'sh0100, 16'sh0300, 16'sh0700, 16'sh0c00,
                        16'sh1200, 16'sh1800, 16'sh1c00, 16'sh1e00};
    for (int i = 0; i < NUM_TAPS; i++) begin
      t[i] = half[(i < 8) ? i : NUM_TAPS - 1 - i];
    end
    return t;
  endfunction

  // half gain on the k = 1 taps, one block of delay
  function automatic taps_t delay_taps();
    taps_t t;
    t = '0;
    for (int p = 0; p < NUM_CHAN; p++) begin
      t[p + NUM_CHAN] = 16'sh4000;
    end
    return t;
  endfunction

  function automatic samples_t gen_samples(input smp_kind_t kind);
    samples_t s;
    // tone 1, j, -1, -j sits in channel 1 under the (-j)^(p*c) kernel
    int       re_lut [4] = '{1, 0, -1, 0};
    int       im_lut [4] = '{0, 1, 0, -1};
    for (int n = 0; n < SMP_PER_TEST; n++) begin
      case (kind)
        KIND_RAMP: begin
          s[n].re = sample_t'(n * 100);
          s[n].im = sample_t'(-n * 50);
        end
        KIND_CONST: begin
          s[n].re = 16'sd1000;
          s[n].im = -16'sd2000;
        end
        KIND_TONE: begin
          s[n].re = sample_t'(TONE_AMP * re_lut[n % 4]);
          s[n].im = sample_t'(TONE_AMP * im_lut[n % 4]);
        end
        default: begin
          s[n].re = sample_t'($urandom);
          s[n].im = sample_t'($urandom);
        end
      endcase
    end
    return s;
  endfunction

  function automatic row_t make_row(input taps_t taps, input taps_t new_taps,
                                    input mask_t mask, input logic set_mask,
                                    input logic bp, input logic [2:0] reload_blk,
                                    input samples_t smp);
    row_t r;
    r.taps       = taps;
    r.new_taps   = new_taps;
    r.smp        = smp;
    r.mask       = mask;
    r.set_mask   = set_mask;
    r.bp         = bp;
    r.reload_blk = reload_blk;
    return r;
  endfunction

  task automatic build_table();
    // first row keeps the reset mask
    rows[0]  = make_row(impulse_taps(), '0, 4'b1111, 1'b0, 1'b0, NO_RELOAD,
                        gen_samples(KIND_RAMP));
    names[0] = "reset_default_mask";
    rows[1]  = make_row(impulse_taps(), '0, 4'b1111, 1'b1, 1'b0, NO_RELOAD,
                        gen_samples(KIND_CONST));
    names[1] = "impulse_const";
    rows[2]  = make_row(impulse_taps(), '0, 4'b1111, 1'b1, 1'b0, NO_RELOAD,
                        gen_samples(KIND_TONE));
    names[2] = "quarter_rate_tone";
    rows[3]  = make_row(lowpass_taps(), '0, 4'b1111, 1'b1, 1'b1, NO_RELOAD,
                        gen_samples(KIND_RAND));
    names[3] = "lowpass_random";
    rows[4]  = make_row(lowpass_taps(), '0, 4'b1010, 1'b1, 1'b0, NO_RELOAD,
                        gen_samples(KIND_RAND));
    names[4] = "mask_1010";
    rows[5]  = make_row(lowpass_taps(), '0, 4'b0000, 1'b1, 1'b0, NO_RELOAD,
                        gen_samples(KIND_RAND));
    names[5] = "mask_zero";
    // reload starts with the samples of block 1
    rows[6]  = make_row(lowpass_taps(), delay_taps(), 4'b1111, 1'b1, 1'b1, 3'd1,
                        gen_samples(KIND_RAND));
    names[6] = "reload_streaming";
  endtask

  // sixteen words, last on the final one
  task automatic load_taps(input taps_t taps);
    for (int i = 0; i < NUM_TAPS; i++) begin
      @(negedge clk);
      s_reload_valid_i = 1'b1;
      s_reload_data_i  = taps[i];
      s_reload_last_i  = (i == NUM_TAPS - 1);
      do @(posedge clk); while (!s_reload_ready_o);
    end
    @(negedge clk);
    s_reload_valid_i = 1'b0;
    s_reload_last_i  = 1'b0;
  endtask

  // select port has no ready, one beat is enough
  task automatic set_mask(input mask_t m);
    @(negedge clk);
    s_select_valid_i = 1'b1;
    s_select_data_i  = {28'h0, m};
    @(negedge clk);
    s_select_valid_i = 1'b0;
  endtask

  task automatic send_samples(input samples_t smp);
    for (int n = 0; n < SMP_PER_TEST; n++) begin
      @(negedge clk);
      s_sample_valid_i = 1'b1;
      s_sample_data_i  = smp[n];
      do @(posedge clk); while (!s_sample_ready_o);
      smp_sent++;
    end
    @(negedge clk);
    s_sample_valid_i = 1'b0;
  endtask

  task automatic drain();
    @(negedge clk);
    // filter back to collecting means the last block went to the DFT
    while (!s_sample_ready_o) begin
      @(negedge clk);
    end
    // every expected beat has been seen on m_out
    while (i_chk.outstanding() != 0) begin
      @(negedge clk);
    end
  endtask

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("timeout: run did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("ERRORS FOUND");
    $finish;
  end

  initial begin
    clk              = 1'b0;
    arst_n_i         = 1'b0;
    s_sample_valid_i = 1'b0;
    s_sample_data_i  = '0;
    s_reload_valid_i = 1'b0;
    s_reload_data_i  = '0;
    s_reload_last_i  = 1'b0;
    s_select_valid_i = 1'b0;
    s_select_data_i  = '0;
    m_out_ready_i    = 1'b1;
    bp_on            = 1'b0;
    smp_sent         = 0;
    void'($urandom(SEED));
    build_table();
    repeat (10) @(negedge clk);
    arst_n_i = 1'b1;
    @(negedge clk);
    for (int t = 0; t < NUM_TESTS; t++) begin
      i_chk.start_test(names[t]);
      if (t == 0) begin
        i_chk.check_idle();
      end
      load_taps(rows[t].taps);
      if (rows[t].set_mask) begin
        set_mask(rows[t].mask);
      end
      bp_on    = rows[t].bp;
      smp_sent = 0;
      fork
        send_samples(rows[t].smp);
        if (rows[t].reload_blk != NO_RELOAD) begin
          wait (smp_sent >= 4 * int'(rows[t].reload_blk));
          load_taps(rows[t].new_taps);
        end
      join
      drain();
      bp_on = 1'b0;
      i_chk.end_test();
    end
    @(negedge clk);
    i_chk.report();
    if (i_chk.error_cnt == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- verilog.f
rtl/chan_pkg.sv
rtl/tap_ram_arbiter.sv
rtl/pfb_filter.sv
rtl/dft4.sv
rtl/chan_select.sv
rtl/chan_top.sv
sim/chan_checker.sv
sim/chan_top_tb.sv

//--- Makefile
# Verilator build and run for the channelizer testbench
VERILATOR ?= verilator
TOP       ?= chan_top_tb
FLIST     ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal -j 0

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FLIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "NO ERRORS" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
